/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int mem_addr_w = 11;
    localparam int mem_depth  = 2048;

    localparam logic [3:0] dev_code_eeprom = 4'b1010;

    localparam logic [31:0] reg_ctrl   = 32'h0;
    localparam logic [31:0] reg_addr   = 32'h4;
    localparam logic [31:0] reg_wdata  = 32'h8;
    localparam logic [31:0] reg_status = 32'hc;

    typedef enum logic [1:0] {
        cmd_start,
        cmd_stop,
        cmd_write_bit,
        cmd_read_bit
    } bus_cmd_e;

    typedef enum logic [3:0] {
        seq_idle,
        seq_start,
        seq_send_byte,
        seq_get_ack,
        seq_restart,
        seq_recv_byte,
        seq_send_nack,
        seq_stop,
        seq_done
    } seq_state_e;

    typedef enum logic [2:0] {
        sl_idle,
        sl_ctrl_byte,
        sl_addr_byte,
        sl_data_in,
        sl_data_out,
        sl_ack_out,
        sl_ack_in,
        sl_wait_stop
    } slave_state_e;

endpackage

/* hdl/eeprom_axil_regs.sv */
`timescale 1ns/1ps

module eeprom_axil_regs
    import eeprom_pkg::*;
(
    input  logic                  sda,
    input  logic                  rst,
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  start,
    output logic                  rnw,
    output logic [3:0]            dev_code,
    output logic [mem_addr_w-1:0] addr,
    output logic [7:0]            wdata_byte,
    input  logic                  done,
    input  logic                  nack,
    input  logic [7:0]            rdata_byte
);

    logic        busy;
    logic        stat_nack;
    logic [7:0]  stat_rdata;
    logic        wr_en;
    logic [31:0] rd_mux;

    assign bresp = 2'b00;
    assign rresp = 2'b00;
    assign wr_en = awready && (wstrb == 4'hf); // Partial writes complete but change nothing

    always_comb
    begin
        case (araddr)
            reg_ctrl:   rd_mux = {24'h0, dev_code, 2'b00, rnw, 1'b0}; // Go always reads 0
            reg_addr:   rd_mux = {{(32 - mem_addr_w){1'b0}}, addr};
            reg_wdata:  rd_mux = {24'h0, wdata_byte};
            reg_status: rd_mux = {16'h0, stat_rdata, 6'h0, stat_nack, busy};
            default:    rd_mux = 32'h0;
        endcase
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            start      <= 1'b0;
            busy       <= 1'b0;
            stat_nack  <= 1'b0;
            stat_rdata <= 8'h00;
            rnw        <= 1'b0;
            dev_code   <= dev_code_eeprom;
            addr       <= '0;
            wdata_byte <= 8'h00;
        end
        else
        begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (awready)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            arready <= arvalid && !rvalid && !arready;
            if (arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            start <= 1'b0;
            if (wr_en)
            begin
                case (awaddr)
                    reg_ctrl:
                    begin
                        rnw      <= wdata[1];
                        dev_code <= wdata[7:4];
                        if (wdata[0] && !busy)
                        begin
                            start <= 1'b1;
                            busy  <= 1'b1;
                        end
                    end
                    reg_addr:  addr       <= wdata[mem_addr_w-1:0];
                    reg_wdata: wdata_byte <= wdata[7:0];
                    default:   ; // Status and unmapped offsets
                endcase
            end

            if (done)
            begin
                busy       <= 1'b0;
                stat_nack  <= nack;
                stat_rdata <= rdata_byte;
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (arready)
            rdata <= rd_mux; // Held until the next accepted read
    end

endmodule

/* hdl/i2c_xfer_seq.sv */
`timescale 1ns/1ps

module i2c_xfer_seq
    import eeprom_pkg::*;
(
    input  logic                  sda,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  rnw,
    input  logic [3:0]            dev_code,
    input  logic [mem_addr_w-1:0] addr,
    input  logic [7:0]            wdata_byte,
    output logic                  done,
    output logic                  nack,
    output logic [7:0]            rdata_byte,
    output bus_cmd_e              cmd,
    output logic                  cmd_bit,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    input  logic                  read_bit
);

    seq_state_e            state;
    logic [2:0]            bit_cnt;
    logic [1:0]            byte_idx; // 0 ctrl, 1 address, 2 data, 3 read ctrl
    logic [7:0]            shift;
    logic                  rnw_q;
    logic [3:0]            dev_q;
    logic [mem_addr_w-1:0] addr_q;
    logic [7:0]            wdata_q;

    assign done = (state == seq_done);

    always_comb
    begin
        cmd       = cmd_write_bit;
        cmd_bit   = 1'b1;
        cmd_valid = 1'b1;
        case (state)
            seq_start,
            seq_restart:   cmd = cmd_start;
            seq_send_byte: cmd_bit = shift[7];
            seq_get_ack,
            seq_recv_byte: cmd = cmd_read_bit;
            seq_send_nack: cmd_bit = 1'b1; // Master nack ends the read
            seq_stop:      cmd = cmd_stop;
            default:       cmd_valid = 1'b0;
        endcase
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state    <= seq_idle;
            bit_cnt  <= 3'd7;
            byte_idx <= 2'd0;
            nack     <= 1'b0;
        end
        else
        begin
            case (state)
                seq_idle:
                    if (start)
                    begin
                        rnw_q    <= rnw;
                        dev_q    <= dev_code;
                        addr_q   <= addr;
                        wdata_q  <= wdata_byte;
                        shift    <= {dev_code, addr[mem_addr_w-1:8], 1'b0};
                        byte_idx <= 2'd0;
                        nack     <= 1'b0;
                        state    <= seq_start;
                    end
                seq_start:
                    if (cmd_ready)
                        state <= seq_send_byte;
                seq_send_byte:
                    if (cmd_ready)
                    begin
                        shift   <= {shift[6:0], 1'b0};
                        bit_cnt <= bit_cnt - 3'd1; // Wraps back to 7 after the last bit
                        if (bit_cnt == 3'd0)
                            state <= seq_get_ack;
                    end
                seq_get_ack:
                    if (cmd_ready)
                    begin
                        if (read_bit)
                        begin
                            nack  <= 1'b1;
                            state <= seq_stop;
                        end
                        else
                        begin
                            case (byte_idx)
                                2'd0:
                                begin
                                    shift    <= addr_q[7:0];
                                    byte_idx <= 2'd1;
                                    state    <= seq_send_byte;
                                end
                                2'd1:
                                begin
                                    shift    <= wdata_q;
                                    byte_idx <= 2'd2;
                                    state    <= rnw_q ? seq_restart : seq_send_byte;
                                end
                                2'd2:    state <= seq_stop;
                                default: state <= seq_recv_byte;
                            endcase
                        end
                    end
                seq_restart:
                    if (cmd_ready)
                    begin
                        shift    <= {dev_q, addr_q[mem_addr_w-1:8], 1'b1};
                        byte_idx <= 2'd3;
                        state    <= seq_send_byte;
                    end
                seq_recv_byte:
                    if (cmd_ready)
                    begin
                        rdata_byte <= {rdata_byte[6:0], read_bit}; // MSB arrives first
                        bit_cnt    <= bit_cnt - 3'd1;
                        if (bit_cnt == 3'd0)
                            state <= seq_send_nack;
                    end
                seq_send_nack:
                    if (cmd_ready)
                        state <= seq_stop;
                seq_stop:
                    if (cmd_ready)
                        state <= seq_done;
                default:
                    state <= seq_idle;
            endcase
        end
    end

endmodule

/* hdl/i2c_bit_ctrl.sv */
`timescale 1ns/1ps

module i2c_bit_ctrl
    import eeprom_pkg::*;
#(
    parameter int SCL_QUARTER = 4
)
(
    input  logic     sda,
    input  logic     rst,
    input  bus_cmd_e cmd,
    input  logic     cmd_bit,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    output logic     read_bit,
    output logic     scl,
    output logic     master_pull,
    input  logic     sdat
);

    localparam int qw = $clog2(SCL_QUARTER);

    logic          active;
    logic [1:0]    phase;
    logic [qw-1:0] qcnt;
    logic          q_end;
    bus_cmd_e      cur_cmd;

    assign q_end = active && (qcnt == qw'(SCL_QUARTER - 1));

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            active      <= 1'b0;
            phase       <= 2'd0;
            qcnt        <= '0;
            cmd_ready   <= 1'b0;
            scl         <= 1'b1;
            master_pull <= 1'b0;
        end
        else
        begin
            cmd_ready <= 1'b0;
            if (!active)
            begin
                if (cmd_valid && !cmd_ready) // Old command still shown during ready
                begin
                    active <= 1'b1;
                    phase  <= 2'd0;
                    qcnt   <= '0;
                    case (cmd)
                        cmd_stop:      master_pull <= 1'b1;
                        cmd_write_bit: master_pull <= !cmd_bit;
                        default:       master_pull <= 1'b0;
                    endcase
                end
            end
            else if (q_end)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: scl <= 1'b1;
                    2'd1:
                    begin
                        if (cur_cmd == cmd_start)
                            master_pull <= 1'b1; // Start condition
                        else if (cur_cmd == cmd_stop)
                            master_pull <= 1'b0; // Stop condition
                    end
                    2'd2:
                    begin
                        if (cur_cmd != cmd_stop)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        active    <= 1'b0;
                        cmd_ready <= 1'b1;
                    end
                endcase
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge sda)
    begin
        if (!active && cmd_valid)
            cur_cmd <= cmd;
        if (q_end && phase == 2'd2)
            read_bit <= sdat; // Sampled at the end of scl high
    end

endmodule

/* hdl/eeprom_slave.sv */
`timescale 1ns/1ps

module eeprom_slave
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic sdat,
    output logic slave_pull
);

    slave_state_e          state;
    slave_state_e          nxt; // Where to go after the ack
    logic [2:0]            scl_sync;
    logic [2:0]            sdat_sync;
    logic                  scl_rise;
    logic                  scl_fall;
    logic                  start_det;
    logic                  stop_det;
    logic [2:0]            bit_cnt;
    logic [7:0]            shift;
    logic [7:0]            byte_in;
    logic [7:0]            rd_byte;
    logic                  ack_on;
    logic [mem_addr_w-1:0] addr;
    logic [7:0]            mem [mem_depth];

    initial
    begin
        for (int i = 0; i < mem_depth; i++)
            mem[i] = 8'h00;
    end

    assign scl_rise  = scl_sync[1] && !scl_sync[2];
    assign scl_fall  = !scl_sync[1] && scl_sync[2];
    assign start_det = scl_sync[1] && scl_sync[2] && sdat_sync[2] && !sdat_sync[1];
    assign stop_det  = scl_sync[1] && scl_sync[2] && !sdat_sync[2] && sdat_sync[1];
    assign byte_in   = {shift[6:0], sdat_sync[1]};

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync   <= 3'b111;
            sdat_sync  <= 3'b111;
            state      <= sl_idle;
            bit_cnt    <= 3'd0;
            ack_on     <= 1'b0;
            slave_pull <= 1'b0;
        end
        else
        begin
            scl_sync  <= {scl_sync[1:0], scl};
            sdat_sync <= {sdat_sync[1:0], sdat};
            if (start_det)
            begin
                state      <= sl_ctrl_byte;
                bit_cnt    <= 3'd0;
                slave_pull <= 1'b0;
            end
            else if (stop_det)
            begin
                state      <= sl_idle;
                slave_pull <= 1'b0;
            end
            else
            begin
                case (state)
                    sl_ctrl_byte, sl_addr_byte, sl_data_in:
                        if (scl_rise)
                        begin
                            shift   <= byte_in;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                ack_on <= 1'b0;
                                state  <= sl_ack_out;
                                case (state)
                                    sl_ctrl_byte:
                                    begin
                                        if (byte_in[7:4] == dev_code_eeprom)
                                        begin
                                            addr[mem_addr_w-1:8] <= byte_in[3:1]; // Block bits
                                            nxt <= byte_in[0] ? sl_data_out : sl_addr_byte;
                                        end
                                        else
                                            state <= sl_wait_stop; // Not our device
                                    end
                                    sl_addr_byte:
                                    begin
                                        addr[7:0] <= byte_in;
                                        nxt       <= sl_data_in;
                                    end
                                    default:
                                    begin
                                        mem[addr] <= byte_in;
                                        nxt       <= sl_wait_stop;
                                    end
                                endcase
                            end
                        end
                    sl_ack_out:
                        if (scl_fall)
                        begin
                            ack_on <= 1'b1;
                            if (!ack_on)
                                slave_pull <= 1'b1;
                            else
                            begin
                                state      <= nxt;
                                rd_byte    <= mem[addr];
                                slave_pull <= (nxt == sl_data_out) && !mem[addr][7];
                            end
                        end
                    sl_data_out:
                        if (scl_fall)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            rd_byte <= {rd_byte[6:0], 1'b0};
                            if (bit_cnt == 3'd7)
                            begin
                                state      <= sl_ack_in;
                                slave_pull <= 1'b0; // Let the master answer
                            end
                            else
                                slave_pull <= !rd_byte[6];
                        end
                    sl_ack_in:
                        if (scl_rise)
                            state <= sl_wait_stop; // Single byte reads only
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hdl/eeprom_subsys_top.sv */
`timescale 1ns/1ps

module eeprom_subsys_top
    import eeprom_pkg::*;
#(
    parameter int SCL_QUARTER = 4
)
(
    input  logic        sda,
    input  logic        rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic                  start;
    logic                  rnw;
    logic [3:0]            dev_code;
    logic [mem_addr_w-1:0] addr;
    logic [7:0]            wdata_byte;
    logic                  done;
    logic                  nack;
    logic [7:0]            rdata_byte;
    bus_cmd_e              cmd;
    logic                  cmd_bit;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  read_bit;
    logic                  scl;
    logic                  master_pull;
    logic                  slave_pull;
    logic                  sdat;

    assign sdat = !(master_pull || slave_pull); // Open-drain bus with pull-up

    eeprom_axil_regs u_regs (
        .sda        (sda),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .start      (start),
        .rnw        (rnw),
        .dev_code   (dev_code),
        .addr       (addr),
        .wdata_byte (wdata_byte),
        .done       (done),
        .nack       (nack),
        .rdata_byte (rdata_byte)
    );

    i2c_xfer_seq u_seq (
        .sda        (sda),
        .rst        (rst),
        .start      (start),
        .rnw        (rnw),
        .dev_code   (dev_code),
        .addr       (addr),
        .wdata_byte (wdata_byte),
        .done       (done),
        .nack       (nack),
        .rdata_byte (rdata_byte),
        .cmd        (cmd),
        .cmd_bit    (cmd_bit),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .read_bit   (read_bit)
    );

    i2c_bit_ctrl #(
        .SCL_QUARTER (SCL_QUARTER)
    ) u_bit (
        .sda         (sda),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_bit     (cmd_bit),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .read_bit    (read_bit),
        .scl         (scl),
        .master_pull (master_pull),
        .sdat        (sdat)
    );

    eeprom_slave u_eeprom (
        .sda        (sda),
        .rst        (rst),
        .scl        (scl),
        .sdat       (sdat),
        .slave_pull (slave_pull)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic sda,
    output logic rst
);

    initial
    begin
        sda = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge sda);
        @(negedge sda);
        rst = 1'b0; // Released on a falling edge, away from the sampling edge
    end

    always #4 sda = ~sda; // 8 ns period

endmodule

/* dv/tb_eeprom_subsys.sv */
`timescale 1ns/1ps

module tb_eeprom_subsys
    import eeprom_pkg::*;
();

    localparam int num_xfers       = 73;  // Bus transfers issued by tests 2 to 5
    localparam int cycles_per_xfer = 700; // A random read is the longest sequence
    localparam int timeout_cycles  = num_xfers * cycles_per_xfer;

    logic        sda;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] lfsr;
    logic [7:0]  ref_mem [mem_depth];
    logic [10:0] wr_addr [32];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] mask_q [$];
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_mask;
    int          err_count;
    int          cycle_cnt;

    tb_clk_gen u_clk (
        .sda (sda),
        .rst (rst)
    );

    eeprom_subsys_top #(
        .SCL_QUARTER (4)
    ) u_dut (
        .sda     (sda),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            err_count++;
            $display("mismatch time=%0t signal=%s got=0x%08h expected=0x%08h",
                     $time, name, got, expected);
            stop_with_failure("a checked value differs from the expected one");
        end
    endtask

    // Galois LFSR stepped once for each bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ 32'h8020_0003;
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // Expected STATUS after a transfer; a good write also updates the model
    function automatic logic [31:0] ref_status(input logic [3:0] code, input logic rnw,
                                               input logic [10:0] a, input logic [7:0] d);
        logic       nack_exp;
        logic [7:0] byte_exp;
        nack_exp = (code != 4'b1010);
        byte_exp = 8'h00;
        if (!nack_exp && !rnw)
            ref_mem[a] = d;
        if (!nack_exp && rnw)
            byte_exp = ref_mem[a];
        return {16'h0, byte_exp, 6'h0, nack_exp, 1'b0};
    endfunction

    task automatic axil_write(input logic [31:0] a, input logic [31:0] d, input int hold);
        awaddr  = a;
        awvalid = 1'b1;
        wdata   = d;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        @(negedge sda);
        while (!awready)
            @(negedge sda);
        check_value("wready", wready, 1'b1);
        @(negedge sda);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (hold)
        begin
            check_value("bvalid", bvalid, 1'b1);
            @(negedge sda);
        end
        check_value("bvalid", bvalid, 1'b1);
        check_value("bresp", bresp, 2'b00);
        bready = 1'b1;
        @(negedge sda);
        bready = 1'b0;
        check_value("bvalid", bvalid, 1'b0);
    endtask

    task automatic axil_read(input logic [31:0] a, input int hold, output logic [31:0] d);
        araddr  = a;
        arvalid = 1'b1;
        @(negedge sda);
        while (!arready)
            @(negedge sda);
        @(negedge sda);
        arvalid = 1'b0;
        d       = rdata;
        repeat (hold)
        begin
            check_value("rvalid", rvalid, 1'b1);
            check_value("rdata", rdata, d); // Must not move while stalled
            @(negedge sda);
        end
        check_value("rvalid", rvalid, 1'b1);
        check_value("rdata", rdata, d);
        check_value("rresp", rresp, 2'b00);
        rready = 1'b1;
        @(negedge sda);
        rready = 1'b0;
        check_value("rvalid", rvalid, 1'b0);
    endtask

    task automatic post_status(input logic [31:0] got, input logic [31:0] expected,
                               input logic [31:0] mask);
        got_q.push_back(got);
        exp_q.push_back(expected);
        mask_q.push_back(mask);
    endtask

    task automatic wait_idle(output logic [31:0] stat);
        axil_read(reg_status, 0, stat);
        while (stat[0])
            axil_read(reg_status, 0, stat);
    endtask

    task automatic run_transfer(input logic [3:0] code, input logic rnw,
                                input logic [10:0] a, input logic [7:0] d);
        logic [31:0] exp_stat;
        logic [31:0] mask;
        logic [31:0] stat;
        axil_write(reg_addr, {21'h0, a}, 0);
        axil_write(reg_wdata, {24'h0, d}, 0);
        axil_write(reg_ctrl, {24'h0, code, 2'b00, rnw, 1'b1}, 0);
        exp_stat = ref_status(code, rnw, a, d);
        mask     = (rnw && code == 4'b1010) ? 32'hffff_ffff : 32'hffff_00ff;
        wait_idle(stat);
        post_status(stat, exp_stat, mask);
    endtask

    always @(negedge sda)
    begin
        if (got_q.size() != 0)
        begin
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_mask = mask_q.pop_front();
            check_value("status", cmp_got & cmp_mask, cmp_exp & cmp_mask);
        end
    end

    always @(posedge sda)
    begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles)
            stop_with_failure($sformatf("timeout after %0d cycles", timeout_cycles));
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] rnd;
        logic [31:0] exp_stat;
        logic [10:0] a;
        logic [10:0] b;
        logic [7:0]  d;
        int          j;

        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'h0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        lfsr      = 32'hb53d_9849;
        err_count = 0;
        cycle_cnt = 0;
        for (int i = 0; i < mem_depth; i++)
            ref_mem[i] = 8'h00;
        @(negedge rst);
        @(negedge sda);

        axil_read(reg_status, 0, r);
        post_status(r, 32'h0, 32'hffff_ffff);
        axil_read(reg_ctrl, 0, r);
        check_value("ctrl", r, 32'h0000_00a0); // Device code 1010 after reset
        axil_write(32'h14, 32'hffff_ffff, 0);
        axil_read(32'h14, 0, r);
        check_value("unmapped", r, 32'h0);

        rnd = take_bits(11);
        a   = rnd[10:0];
        rnd = take_bits(8);
        d   = rnd[7:0];
        run_transfer(4'b1010, 1'b0, a, d);
        run_transfer(4'b1010, 1'b1, a, 8'h00);
        run_transfer(4'b1010, 1'b1, a ^ 11'h400, 8'h00); // Never written

        for (int i = 0; i < 32; i++)
        begin
            rnd        = take_bits(8);
            wr_addr[i] = {3'(i), rnd[7:0]}; // Every block gets four writes
            rnd        = take_bits(8);
            run_transfer(4'b1010, 1'b0, wr_addr[i], rnd[7:0]);
        end
        for (int i = 0; i < 32; i++)
        begin
            j = (i * 13) % 32;
            run_transfer(4'b1010, 1'b1, wr_addr[j], 8'h00);
        end

        a   = wr_addr[5];
        rnd = take_bits(8);
        run_transfer(4'b1011, 1'b0, a, rnd[7:0]);
        run_transfer(4'b1011, 1'b1, a, 8'h00);
        axil_read(reg_addr, 0, r);
        check_value("addr", r, {21'h0, a});
        run_transfer(4'b1010, 1'b1, a, 8'h00);

        rnd = take_bits(11);
        a   = rnd[10:0];
        b   = a ^ 11'h0a5;
        rnd = take_bits(8);
        d   = rnd[7:0];
        axil_write(reg_addr, {21'h0, a}, 0);
        axil_write(reg_wdata, {24'h0, d}, 0);
        axil_write(reg_ctrl, 32'h0000_00a1, 0);
        exp_stat = ref_status(4'b1010, 1'b0, a, d);
        axil_read(reg_status, 0, r);
        post_status(r, 32'h1, 32'h1);
        axil_write(reg_addr, {21'h0, b}, 0);
        axil_write(reg_wdata, {24'h0, ~d}, 0);
        axil_write(reg_ctrl, 32'h0000_00a1, 0); // Dropped while the first write runs
        axil_read(reg_status, 0, r);
        post_status(r, 32'h1, 32'h1);
        wait_idle(r);
        post_status(r, exp_stat, 32'hffff_00ff);
        run_transfer(4'b1010, 1'b1, a, 8'h00);
        run_transfer(4'b1010, 1'b1, b, 8'h00);

        for (int i = 0; i < 6; i++)
        begin
            rnd = take_bits(8);
            d   = rnd[7:0];
            rnd = take_bits(4);
            axil_write(reg_wdata, {24'h0, d}, rnd[3:0]);
            rnd = take_bits(4);
            axil_read(reg_wdata, rnd[3:0], r);
            check_value("wdata", r, {24'h0, d});
        end
        rnd = take_bits(4);
        axil_read(reg_status, rnd[3:0], r);
        post_status(r, 32'h0, 32'h3);

        while (got_q.size() != 0)
            @(negedge sda);
        @(negedge sda);
        if (err_count == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
            stop_with_failure("one or more checks failed");
    end

endmodule

/* eeprom_i2c.f */
hdl/eeprom_pkg.sv
hdl/eeprom_axil_regs.sv
hdl/i2c_xfer_seq.sv
hdl/i2c_bit_ctrl.sv
hdl/eeprom_slave.sv
hdl/eeprom_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_eeprom_subsys.sv
